/* Makefile */
TOP = tb_pio

.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* pio_axi_pkg.sv */
`default_nettype none

package pio_axi_pkg;

    localparam int AXIL_ADDR_W = 4;                   // Four word registers
    localparam int AXIL_DATA_W = 32;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     awvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     wvalid;
        logic                     bready;
        logic [AXIL_ADDR_W-1:0]   araddr;
        logic                     arvalid;
        logic                     rready;
    } axil_req_t;

    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic [1:0]             bresp;
        logic                   bvalid;
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rsp_t;

endpackage

`default_nettype wire

/* pio_axil_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pio_settings.svh"

module pio_axil_regs
    import pio_axi_pkg::*;
    import pio_reg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  axil_req_t             s_axil_req,
    output axil_rsp_t             s_axil_rsp,
    input  logic [`PIO_WIDTH-1:0] level,
    input  logic [`PIO_WIDTH-1:0] capture,
    output pio_cfg_t              cfg,
    output logic [`PIO_WIDTH-1:0] mask,
    output logic [`PIO_WIDTH-1:0] clr_mask
);

    logic                   wr_ready_q;               // Drives awready and wready
    logic                   b_valid_q;
    logic                   ar_ready_q;
    logic                   r_valid_q;
    logic [AXIL_DATA_W-1:0] r_data_q;
    logic                   wr_go;
    logic                   rd_go;
    logic [AXIL_DATA_W-1:0] rd_word;
    pio_cfg_t               cfg_q;
    logic [`PIO_WIDTH-1:0]  mask_q;

    assign wr_go = wr_ready_q & s_axil_req.awvalid & s_axil_req.wvalid;
    assign rd_go = ar_ready_q & s_axil_req.arvalid;

    // Write channel, AW and W are taken together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ready_q <= 1'b0;
            b_valid_q  <= 1'b0;
        end else begin
            wr_ready_q <= s_axil_req.awvalid & s_axil_req.wvalid &
                          ~b_valid_q & ~wr_ready_q;
            if (wr_go) begin
                b_valid_q <= 1'b1;
            end else if (s_axil_req.bready) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q  <= '0;
            mask_q <= '0;
        end else if (wr_go && s_axil_req.wstrb[0]) begin
            case (s_axil_req.awaddr)
                REG_CFG:  cfg_q  <= pio_cfg_t'(s_axil_req.wdata[$bits(pio_cfg_t)-1:0]);
                REG_MASK: mask_q <= s_axil_req.wdata[`PIO_WIDTH-1:0];
                default: ;                            // Other offsets are read only
            endcase
        end
    end

    // One-cycle clear pulse, capture block drops the bits on this edge
    assign clr_mask = (wr_go && s_axil_req.awaddr == REG_CAPTURE) ?
                      s_axil_req.wdata[`PIO_WIDTH-1:0] : '0;

    always_comb begin
        rd_word = '0;
        case (s_axil_req.araddr)
            REG_DATA:    rd_word[`PIO_WIDTH-1:0]      = level;
            REG_CFG:     rd_word[$bits(pio_cfg_t)-1:0] = cfg_q;
            REG_MASK:    rd_word[`PIO_WIDTH-1:0]      = mask_q;
            REG_CAPTURE: rd_word[`PIO_WIDTH-1:0]      = capture;
            default:     rd_word = '0;
        endcase
    end

    // Read channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b0;
        end else begin
            ar_ready_q <= s_axil_req.arvalid & ~r_valid_q & ~ar_ready_q;
            if (rd_go) begin
                r_valid_q <= 1'b1;
            end else if (s_axil_req.rready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            r_data_q <= rd_word;                      // Held until rready
        end
    end

    always_comb begin
        s_axil_rsp         = '0;
        s_axil_rsp.awready = wr_ready_q;
        s_axil_rsp.wready  = wr_ready_q;
        s_axil_rsp.bresp   = AXI_RESP_OKAY;
        s_axil_rsp.bvalid  = b_valid_q;
        s_axil_rsp.arready = ar_ready_q;
        s_axil_rsp.rdata   = r_valid_q ? r_data_q : '0;
        s_axil_rsp.rresp   = AXI_RESP_OKAY;
        s_axil_rsp.rvalid  = r_valid_q;
    end

    assign cfg  = cfg_q;
    assign mask = mask_q;

endmodule

`default_nettype wire

/* pio_edge_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pio_settings.svh"

module pio_edge_capture
    import pio_reg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  edge_event_t           raw_ev,
    input  edge_event_t           filt_ev,
    input  pio_cfg_t              cfg,
    input  logic [`PIO_WIDTH-1:0] mask,
    input  logic [`PIO_WIDTH-1:0] clr_mask,
    output logic [`PIO_WIDTH-1:0] capture,
    output logic                  irq
);

    edge_event_t           src_ev;                    // Path chosen by noise_en
    logic [`PIO_WIDTH-1:0] sel_edges;
    logic [`PIO_WIDTH-1:0] set_bits;
    logic [`PIO_WIDTH-1:0] capture_q;
    logic                  irq_q;

    assign src_ev = cfg.noise_en ? filt_ev : raw_ev;

    always_comb begin
        sel_edges = '0;
        if (sel_has_rise(cfg.edge_sel)) begin
            sel_edges = sel_edges | src_ev.rise;
        end
        if (sel_has_fall(cfg.edge_sel)) begin
            sel_edges = sel_edges | src_ev.fall;
        end
    end

    assign set_bits = cfg.enable ? sel_edges : '0;   // Disabled port keeps old bits

    // New edges override a clear landing in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            capture_q <= '0;
        end else begin
            capture_q <= (capture_q & ~clr_mask) | set_bits;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q <= 1'b0;
        end else if (cfg.irq_level) begin
            irq_q <= |(src_ev.level & mask);          // Level mode
        end else begin
            irq_q <= |(capture_q & mask);             // Edge mode
        end
    end

    assign capture = capture_q;
    assign irq     = irq_q;

endmodule

`default_nettype wire

/* pio_edge_detector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pio_settings.svh"

module pio_edge_detector
    import pio_reg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`PIO_WIDTH-1:0] pins,
    output edge_event_t           raw_ev
);

    logic [`PIO_WIDTH-1:0] sync1;                     // First synchronizer stage
    logic [`PIO_WIDTH-1:0] sync2;
    logic [`PIO_WIDTH-1:0] prev_level;
    logic [`PIO_WIDTH-1:0] rise_q;
    logic [`PIO_WIDTH-1:0] fall_q;

    // Two flops against metastability on the asynchronous pins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1 <= '0;
            sync2 <= '0;
        end else begin
            sync1 <= pins;
            sync2 <= sync1;
        end
    end

    // Third stage compares against the level one cycle back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_level <= '0;
            rise_q     <= '0;
            fall_q     <= '0;
        end else begin
            prev_level <= sync2;
            rise_q     <= sync2 & ~prev_level;        // Low to high
            fall_q     <= ~sync2 & prev_level;        // High to low
        end
    end

    assign raw_ev.rise  = rise_q;
    assign raw_ev.fall  = fall_q;
    assign raw_ev.level = sync2;

endmodule

`default_nettype wire

/* pio_glitch_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pio_settings.svh"

module pio_glitch_filter
    import pio_reg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`PIO_WIDTH-1:0] pins,
    output edge_event_t           filt_ev
);

    localparam int DIV_W = $clog2(`PIO_FILTER_DIV + 1);
    localparam int CNT_W = $clog2(`PIO_FILTER_COUNT + 1);

    logic [`PIO_WIDTH-1:0] sync1;
    logic [`PIO_WIDTH-1:0] sync2;
    logic [DIV_W-1:0]      div_cnt;
    logic                  tick;                      // One sample per divider period
    logic [`PIO_WIDTH-1:0] acc_level;                 // Accepted, debounced level
    logic [`PIO_WIDTH-1:0] rise_q;
    logic [`PIO_WIDTH-1:0] fall_q;
    logic [CNT_W-1:0]      stab_cnt [`PIO_WIDTH];

    // Private synchronizer, the raw path may be tuned separately
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1 <= '0;
            sync2 <= '0;
        end else begin
            sync1 <= pins;
            sync2 <= sync1;
        end
    end

    assign tick = (div_cnt == DIV_W'(`PIO_FILTER_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // A pin must disagree with acc_level on COUNT ticks in a row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_level <= '0;
            rise_q    <= '0;
            fall_q    <= '0;
            for (int i = 0; i < `PIO_WIDTH; i++) begin
                stab_cnt[i] <= '0;
            end
        end else begin
            rise_q <= '0;                             // Pulses last one cycle
            fall_q <= '0;
            for (int i = 0; i < `PIO_WIDTH; i++) begin
                if (tick) begin
                    if (sync2[i] == acc_level[i]) begin
                        stab_cnt[i] <= '0;            // Glitch gone, start over
                    end else if (stab_cnt[i] == CNT_W'(`PIO_FILTER_COUNT - 1)) begin
                        stab_cnt[i]  <= '0;
                        acc_level[i] <= sync2[i];
                        rise_q[i]    <= sync2[i];
                        fall_q[i]    <= ~sync2[i];
                    end else begin
                        stab_cnt[i] <= stab_cnt[i] + 1'b1;
                    end
                end
            end
        end
    end

    assign filt_ev.rise  = rise_q;
    assign filt_ev.fall  = fall_q;
    assign filt_ev.level = acc_level;

endmodule

`default_nettype wire

/* pio_reg_pkg.sv */
`default_nettype none

`include "pio_settings.svh"

package pio_reg_pkg;

    // Byte offsets in the register window
    localparam logic [3:0] REG_DATA    = 4'h0;        // Synchronized pin levels
    localparam logic [3:0] REG_CFG     = 4'h4;
    localparam logic [3:0] REG_MASK    = 4'h8;        // Interrupt mask
    localparam logic [3:0] REG_CAPTURE = 4'hC;        // Sticky edges cleared by writing ones

    // Edge selection codes
    localparam logic [1:0] EDGE_NONE = 2'b00;
    localparam logic [1:0] EDGE_RISE = 2'b01;
    localparam logic [1:0] EDGE_FALL = 2'b10;
    localparam logic [1:0] EDGE_BOTH = 2'b11;

    // Bit 0 is enable, bits 2:1 edge_sel, bit 3 noise_en, bit 4 irq_level
    typedef struct packed {
        logic       irq_level;                        // 1 = level mode
        logic       noise_en;                         // Use filtered path
        logic [1:0] edge_sel;
        logic       enable;
    } pio_cfg_t;

    // Per-pin pulses and level produced by both input paths
    typedef struct packed {
        logic [`PIO_WIDTH-1:0] rise;
        logic [`PIO_WIDTH-1:0] fall;
        logic [`PIO_WIDTH-1:0] level;
    } edge_event_t;

    // Rising and falling parts of an edge_sel code
    function automatic logic sel_has_rise(input logic [1:0] sel);
        return (sel == EDGE_RISE) || (sel == EDGE_BOTH);
    endfunction

    function automatic logic sel_has_fall(input logic [1:0] sel);
        return (sel == EDGE_FALL) || (sel == EDGE_BOTH);
    endfunction

endpackage

`default_nettype wire

/* pio_settings.svh */
`ifndef PIO_SETTINGS_SVH
`define PIO_SETTINGS_SVH

// Number of input pins on the port
`define PIO_WIDTH 8

// clk cycles between two samples of the noise filter
`define PIO_FILTER_DIV 4

// Consecutive differing samples before the filtered level flips
`define PIO_FILTER_COUNT 3

`endif

/* pio_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pio_settings.svh"

module pio_top
    import pio_axi_pkg::*;
    import pio_reg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`PIO_WIDTH-1:0] pins,
    input  axil_req_t             s_axil_req,
    output axil_rsp_t             s_axil_rsp,
    output logic                  irq
);

    edge_event_t           raw_ev;                    // Unfiltered path
    edge_event_t           filt_ev;
    pio_cfg_t              cfg;
    logic [`PIO_WIDTH-1:0] mask;
    logic [`PIO_WIDTH-1:0] clr_mask;
    logic [`PIO_WIDTH-1:0] capture;

    pio_edge_detector u_edge_detector (
        .clk    (clk),
        .rst_n  (rst_n),
        .pins   (pins),
        .raw_ev (raw_ev)
    );

    pio_glitch_filter u_glitch_filter (
        .clk     (clk),
        .rst_n   (rst_n),
        .pins    (pins),
        .filt_ev (filt_ev)
    );

    pio_edge_capture u_edge_capture (
        .clk      (clk),
        .rst_n    (rst_n),
        .raw_ev   (raw_ev),
        .filt_ev  (filt_ev),
        .cfg      (cfg),
        .mask     (mask),
        .clr_mask (clr_mask),
        .capture  (capture),
        .irq      (irq)
    );

    // REG_DATA always shows the raw synchronized level
    pio_axil_regs u_axil_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .s_axil_req (s_axil_req),
        .s_axil_rsp (s_axil_rsp),
        .level      (raw_ev.level),
        .capture    (capture),
        .cfg        (cfg),
        .mask       (mask),
        .clr_mask   (clr_mask)
    );

endmodule

`default_nettype wire

/* tb_pio.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pio_settings.svh"

module tb_pio
    import pio_axi_pkg::*;
    import pio_reg_pkg::*;
();

    localparam int W         = `PIO_WIDTH;
    localparam int NUM_TESTS = 6;
    // Longer than the worst filter latency of (COUNT+1)*DIV+3 cycles
    localparam int SETTLE    = (`PIO_FILTER_COUNT + 1) * `PIO_FILTER_DIV + 5;
    localparam logic [31:0] ALL_PINS = 32'((1 << W) - 1);

    logic         clk = 1'b0;
    logic         rst_n;
    logic [W-1:0] pins;
    axil_req_t    req;
    axil_rsp_t    rsp;
    logic         irq;
    integer       seed = 74;
    int           checks = 0;
    int           errors = 0;
    int           failed_tests = 0;
    int           test_errors = 0;
    logic [31:0]  rd;
    logic [31:0]  cw;                                 // Last config word written
    logic [W-1:0] cap;                                // Expected capture bits
    logic [W-1:0] msk;
    logic [W-1:0] cur;
    logic [W-1:0] nxt;

    pio_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .pins       (pins),
        .s_axil_req (req),
        .s_axil_rsp (rsp),
        .irq        (irq)
    );

    always #5 clk = ~clk;

    // Expected sticky bits after pins move from prev to now
    function automatic logic [W-1:0] ref_capture(input logic [W-1:0] prev,
                                                 input logic [W-1:0] now,
                                                 input logic [1:0]   sel,
                                                 input logic         en,
                                                 input logic [W-1:0] old);
        logic [W-1:0] hit;
        hit = (sel[0] ? (now & ~prev) : '0) | (sel[1] ? (prev & ~now) : '0);
        return en ? (old | hit) : old;
    endfunction

    function automatic logic [31:0] cfg_word(input logic en, input logic [1:0] sel,
                                             input logic noise, input logic lvl);
        return {27'b0, lvl, noise, sel, en};
    endfunction

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic drive_pins(input logic [W-1:0] value);
        @(posedge clk);
        pins <= value;
    endtask

    task automatic settle();
        repeat (SETTLE) @(posedge clk);
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
        int n;
        n = 0;
        @(posedge clk);
        req.awaddr  <= addr;
        req.awvalid <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= 4'hF;
        req.wvalid  <= 1'b1;
        req.bready  <= 1'b1;
        @(negedge clk);
        while (!rsp.awready && n < 16) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);                               // AW and W handshake
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!rsp.bvalid && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (!rsp.bvalid) begin
            $display("Write to offset %h got no write response from the DUT", addr);
            errors++;
        end
        check_eq(32'(rsp.bresp), 32'(AXI_RESP_OKAY), "write response code");
        @(posedge clk);
        req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        int n;
        n = 0;
        @(posedge clk);
        req.araddr  <= addr;
        req.arvalid <= 1'b1;
        req.rready  <= 1'b1;
        @(negedge clk);
        while (!rsp.arready && n < 16) begin
            @(negedge clk);
            n++;
        end
        @(posedge clk);
        req.arvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!rsp.rvalid && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (!rsp.rvalid) begin
            $display("Read from offset %h got no read response from the DUT", addr);
            errors++;
        end
        data = rsp.rdata;
        check_eq(32'(rsp.rresp), 32'(AXI_RESP_OKAY), "read response code");
        @(posedge clk);
        req.rready <= 1'b0;
    endtask

    // irq is registered, give it two cycles
    task automatic irq_check(input logic expected, input string what);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_eq(32'(irq), 32'(expected), what);
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == test_errors) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: FAILED with %0d errors", num, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        req   <= '0;
        pins  <= '0;
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        settle();

        for (int a = 0; a < 4; a++) begin
            axil_read(4'(a * 4), rd);
            check_eq(rd, 32'h0, "register value after reset");
        end
        @(negedge clk);
        check_eq(32'(irq), 32'h0, "irq after reset");
        repeat (3) begin
            nxt = W'($random(seed));
            drive_pins(nxt);
            settle();
            axil_read(REG_DATA, rd);
            check_eq(rd, 32'(nxt), "REG_DATA pin level");
        end
        report_test(1, "reset values and pin levels");

        // Pass 4 uses both edges with the port disabled
        for (int s = 0; s < 5; s++) begin
            cw = cfg_word(s < 4, (s < 4) ? 2'(s) : 2'b11, 1'b0, 1'b0);
            axil_write(REG_CFG, cw);
            axil_read(REG_CFG, rd);
            check_eq(rd, cw, "REG_CFG read-back");
            axil_write(REG_CAPTURE, ALL_PINS);
            cap = '0;
            repeat (2) begin
                nxt = W'($random(seed));
                cap = ref_capture(pins, nxt, cw[2:1], cw[0], cap);
                drive_pins(nxt);
                settle();
                axil_read(REG_CAPTURE, rd);
                check_eq(rd, 32'(cap), "capture bits for edge_sel");
            end
        end
        report_test(2, "edge selection and enable");

        axil_write(REG_CFG, cfg_word(1'b1, 2'b11, 1'b0, 1'b0));
        axil_write(REG_CAPTURE, ALL_PINS);
        nxt = ~pins;                                  // Every pin toggles
        cap = ref_capture(pins, nxt, 2'b11, 1'b1, '0);
        drive_pins(nxt);
        settle();
        msk = W'($random(seed));
        axil_write(REG_CAPTURE, 32'(msk));
        cap = cap & ~msk;
        axil_read(REG_CAPTURE, rd);
        check_eq(rd, 32'(cap), "capture after partial clear");
        report_test(3, "write one to clear");

        nxt = ~pins;
        cap = ref_capture(pins, nxt, 2'b11, 1'b1, cap);
        drive_pins(nxt);
        settle();
        msk = W'($random(seed));
        axil_write(REG_MASK, 32'(msk));
        irq_check(|(cap & msk), "edge irq after mask change");
        axil_write(REG_MASK, 32'h0);
        irq_check(1'b0, "edge irq with mask cleared");
        msk = W'($random(seed)) | W'(1);
        axil_write(REG_MASK, 32'(msk));
        axil_write(REG_CAPTURE, 32'(msk & ~W'(1)));   // Keep only bit 0 of the masked ones
        cap = cap & ~(msk & ~W'(1));
        irq_check(|(cap & msk), "edge irq after partial clear");
        axil_write(REG_CAPTURE, 32'(cap));
        cap = '0;
        irq_check(1'b0, "edge irq after full clear");
        report_test(4, "edge mode irq");

        axil_write(REG_CFG, cfg_word(1'b1, 2'b11, 1'b1, 1'b0));
        axil_write(REG_CAPTURE, ALL_PINS);
        cur = pins;
        nxt = cur ^ W'(1);
        drive_pins(nxt);
        drive_pins(cur);
        settle();
        axil_read(REG_CAPTURE, rd);
        check_eq(rd, 32'h0, "one-cycle glitch through noise filter");
        drive_pins(nxt);
        repeat (40) @(posedge clk);
        cap = ref_capture(cur, nxt, 2'b11, 1'b1, '0);
        axil_read(REG_CAPTURE, rd);
        check_eq(rd, 32'(cap), "held change through noise filter");
        for (int s = 1; s < 3; s++) begin
            axil_write(REG_CFG, cfg_word(1'b1, 2'(s), 1'b0, 1'b0));
            axil_write(REG_CAPTURE, ALL_PINS);
            cur = pins;
            nxt = cur ^ W'(1);
            cap = ref_capture(nxt, cur, 2'(s), 1'b1, ref_capture(cur, nxt, 2'(s), 1'b1, '0));
            drive_pins(nxt);
            drive_pins(cur);
            settle();
            axil_read(REG_CAPTURE, rd);
            check_eq(rd, 32'(cap), "one-cycle glitch on raw path");
        end
        report_test(5, "noise filter");

        msk = W'($random(seed));
        axil_write(REG_MASK, 32'(msk));
        axil_write(REG_CFG, cfg_word(1'b1, 2'b11, 1'b0, 1'b1));
        repeat (3) begin
            nxt = W'($random(seed));
            drive_pins(nxt);
            settle();
            irq_check(|(nxt & msk), "level mode irq");
        end
        report_test(6, "level mode irq");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 NUM_TESTS, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog, about 2 us per test
    initial begin
        #(NUM_TESTS * 2000);
        $display("Timeout: the tests were still running after %0d ns", NUM_TESTS * 2000);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
pio_axi_pkg.sv
pio_reg_pkg.sv
pio_edge_detector.sv
pio_glitch_filter.sv
pio_edge_capture.sv
pio_axil_regs.sv
pio_top.sv
tb_pio.sv
